/* list.f */
logic/map_pkg.sv
logic/apb_pkg.sv
logic/map_apb_regs.sv
logic/map_control.sv
logic/map_position_counter.sv
logic/map_line_buffer.sv
logic/map_column_sum.sv
logic/map_filter_top.sv
tb/map_filter_assert.sv
tb/map_filter_tb.sv

/* logic/apb_pkg.sv */
package apb_pkg;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic        pready;
    logic        pslverr;
    logic [31:0] prdata;
  } apb_rsp_t;

  // register map
  localparam logic [3:0] REG_CTRL   = 4'h0;
  localparam logic [3:0] REG_STATUS = 4'h4;
  localparam logic [3:0] REG_PIXEL  = 4'h8;
  localparam logic [3:0] REG_RESULT = 4'hC;

endpackage

/* logic/map_apb_regs.sv */
`timescale 1ns/100ps

module map_apb_regs (
  input  logic              clk,
  input  logic              nrst,
  input  apb_pkg::apb_req_t req,
  output apb_pkg::apb_rsp_t rsp,
  output logic              start_cmd,
  output logic              pix_valid,
  output map_pkg::pixel_t   pix,
  input  logic              busy,
  input  logic              done,
  input  logic              stall_en,
  input  logic              res_valid,
  input  map_pkg::sum_t     res,
  input  map_pkg::map_pos_t res_pos
);

  logic              access;
  logic              pix_wr;
  logic              hold;
  logic              xfer_done;
  logic              wr;
  logic              rd;
  logic              res_full;
  map_pkg::sum_t     res_sum;
  map_pkg::map_pos_t res_loc;

  assign access = req.psel & req.penable;
  assign pix_wr = req.pwrite & (req.paddr == apb_pkg::REG_PIXEL);
  // hold pixel writes until the pending result is read
  assign hold = access & pix_wr & res_full & stall_en;
  assign xfer_done = access & ~hold;
  assign wr = xfer_done & req.pwrite;
  assign rd = xfer_done & ~req.pwrite;

  assign start_cmd = wr & (req.paddr == apb_pkg::REG_CTRL) & req.pwdata[0];
  assign pix_valid = xfer_done & pix_wr;
  assign pix = req.pwdata[7:0];

  always_ff @(posedge clk or negedge nrst)
  begin
    if (!nrst)
    begin
      res_full <= 1'b0;
    end
    else if (res_valid)
    begin
      res_full <= 1'b1;
    end
    else if (rd && req.paddr == apb_pkg::REG_RESULT)
    begin
      res_full <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (res_valid)
    begin
      res_sum <= res;
      res_loc <= res_pos;
    end
  end

  always_comb
  begin
    rsp.pready = xfer_done;
    rsp.pslverr = rd & (req.paddr == apb_pkg::REG_RESULT) & ~res_full;
    rsp.prdata = '0;
    if (rd)
    begin
      case (req.paddr)
        apb_pkg::REG_STATUS:
        begin
          rsp.prdata[2:0] = {res_full, done, busy};
        end
        apb_pkg::REG_RESULT:
        begin
          rsp.prdata[10:0] = res_sum;
          rsp.prdata[20:16] = res_loc.row;
          rsp.prdata[28:24] = res_loc.col;
        end
        default:
        begin
          rsp.prdata = '0;
        end
      endcase
    end
  end

endmodule

/* logic/map_column_sum.sv */
`timescale 1ns/100ps

module map_column_sum (
  input  logic                                    clk,
  input  logic                                    nrst,
  input  logic                                    emit,
  input  logic                                    adv,
  input  map_pkg::pixel_t                         din,
  input  map_pkg::pixel_t [map_pkg::BUF_ROWS-1:0] taps,
  input  map_pkg::map_pos_t                       pos,
  output logic                                    res_valid,
  output map_pkg::sum_t                           res,
  output map_pkg::map_pos_t                       res_pos
);

  map_pkg::sum_t sum;

  // current pixel plus the older rows of the window
  always_comb
  begin
    sum = map_pkg::sum_t'(din);
    for (int i = 0; i < map_pkg::WIN_ROWS - 1; i++)
    begin
      sum = sum + map_pkg::sum_t'(taps[i]);
    end
  end

  always_ff @(posedge clk or negedge nrst)
  begin
    if (!nrst)
    begin
      res_valid <= 1'b0;
    end
    else
    begin
      res_valid <= adv & emit;
    end
  end

  always_ff @(posedge clk)
  begin
    if (adv && emit)
    begin
      res <= sum;
      res_pos <= pos;
    end
  end

endmodule

/* logic/map_control.sv */
`timescale 1ns/100ps

module map_control (
  input  logic              clk,
  input  logic              nrst,
  input  logic              start_cmd,
  input  logic              pix_valid,
  input  logic              last_col,
  input  map_pkg::map_pos_t pos,
  input  logic              last_pixel,
  output logic              adv,
  output logic              emit,
  output logic              busy,
  output logic              done,
  output logic              clr,
  output logic              stall_en
);

  map_pkg::map_state_t state;
  map_pkg::map_state_t state_nxt;
  logic                start_ok;
  logic                buf_full;

  // start is only taken from idle
  assign start_ok = start_cmd & (state == map_pkg::st_idle);
  assign adv = pix_valid & (state != map_pkg::st_idle);
  assign emit = (state == map_pkg::st_working);
  assign stall_en = emit;
  assign busy = (state != map_pkg::st_idle);
  assign clr = start_ok;

  // last pixel of row 3 fills the line buffer
  assign buf_full = last_col & (pos.row == map_pkg::row_t'(map_pkg::WIN_ROWS - 2));

  always_comb
  begin
    state_nxt = state;
    case (state)
      map_pkg::st_idle:
      begin
        if (start_ok)
        begin
          state_nxt = map_pkg::st_buffering;
        end
      end
      map_pkg::st_buffering:
      begin
        if (adv && buf_full)
        begin
          state_nxt = map_pkg::st_working;
        end
      end
      map_pkg::st_working:
      begin
        if (adv && last_pixel)
        begin
          state_nxt = map_pkg::st_idle;
        end
      end
      default:
      begin
        state_nxt = map_pkg::st_idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge nrst)
  begin
    if (!nrst)
    begin
      state <= map_pkg::st_idle;
      done <= 1'b0;
    end
    else
    begin
      state <= state_nxt;
      if (start_ok)
      begin
        done <= 1'b0;
      end
      else if (emit && adv && last_pixel)
      begin
        done <= 1'b1;
      end
    end
  end

endmodule

/* logic/map_filter_top.sv */
`timescale 1ns/100ps

module map_filter_top (
  input  logic              clk,
  input  logic              nrst,
  input  apb_pkg::apb_req_t req,
  output apb_pkg::apb_rsp_t rsp
);

  logic                                    start_cmd;
  logic                                    pix_valid;
  map_pkg::pixel_t                         pix;
  logic                                    busy;
  logic                                    done;
  logic                                    clr;
  logic                                    stall_en;
  logic                                    adv;
  logic                                    emit;
  map_pkg::map_pos_t                       pos;
  logic                                    last_col;
  logic                                    last_pixel;
  map_pkg::pixel_t [map_pkg::BUF_ROWS-1:0] taps;
  logic                                    res_valid;
  map_pkg::sum_t                           res;
  map_pkg::map_pos_t                       res_pos;

  map_apb_regs i_map_apb_regs (
    .clk(clk), .nrst(nrst), .req(req), .rsp(rsp),
    .start_cmd(start_cmd), .pix_valid(pix_valid), .pix(pix),
    .busy(busy), .done(done), .stall_en(stall_en),
    .res_valid(res_valid), .res(res), .res_pos(res_pos)
  );

  map_control i_map_control (
    .clk(clk), .nrst(nrst), .start_cmd(start_cmd), .pix_valid(pix_valid),
    .last_col(last_col), .pos(pos), .last_pixel(last_pixel),
    .adv(adv), .emit(emit), .busy(busy), .done(done),
    .clr(clr), .stall_en(stall_en)
  );

  map_position_counter i_map_position_counter (
    .clk(clk), .nrst(nrst), .clr(clr), .adv(adv),
    .pos(pos), .last_col(last_col), .last_pixel(last_pixel)
  );

  map_line_buffer #(.elem_t(map_pkg::pixel_t)) i_map_line_buffer (
    .clk(clk), .nrst(nrst), .adv(adv), .din(pix), .taps(taps)
  );

  map_column_sum i_map_column_sum (
    .clk(clk), .nrst(nrst), .emit(emit), .adv(adv), .din(pix), .taps(taps),
    .pos(pos), .res_valid(res_valid), .res(res), .res_pos(res_pos)
  );

endmodule

/* logic/map_line_buffer.sv */
`timescale 1ns/100ps

module map_line_buffer #(
  parameter type elem_t = map_pkg::pixel_t
) (
  input  logic                             clk,
  input  logic                             nrst,
  input  logic                             adv,
  input  elem_t                            din,
  output elem_t [map_pkg::BUF_ROWS-1:0]    taps
);

  localparam int NROWS = map_pkg::BUF_ROWS;
  localparam int NCOLS = map_pkg::MAP_COLS;

  elem_t line [NROWS][NCOLS];

  // each row is one map row long, so its tail is the same column one row back
  always_ff @(posedge clk or negedge nrst)
  begin
    if (!nrst)
    begin
      for (int r = 0; r < NROWS; r++)
      begin
        for (int c = 0; c < NCOLS; c++)
        begin
          line[r][c] <= '0;
        end
      end
    end
    else if (adv)
    begin
      line[0][0] <= din;
      for (int r = 1; r < NROWS; r++)
      begin
        line[r][0] <= line[r-1][NCOLS-1];
      end
      for (int r = 0; r < NROWS; r++)
      begin
        for (int c = 1; c < NCOLS; c++)
        begin
          line[r][c] <= line[r][c-1];
        end
      end
    end
  end

  always_comb
  begin
    for (int r = 0; r < NROWS; r++)
    begin
      taps[r] = line[r][NCOLS-1];
    end
  end

endmodule

/* logic/map_pkg.sv */
package map_pkg;

  // map geometry, one PU per column
  localparam int MAP_COLS = 28;
  localparam int MAP_ROWS = 28;
  localparam int WIN_ROWS = 5;
  localparam int BUF_ROWS = 4;

  typedef logic [7:0] pixel_t;
  // five taps of 255 need 11 bits
  typedef logic [10:0] sum_t;
  typedef logic [4:0] col_t;
  typedef logic [4:0] row_t;

  typedef struct packed {
    row_t row;
    col_t col;
  } map_pos_t;

  typedef enum logic [1:0] {
    st_idle      = 2'b00,
    st_buffering = 2'b01,
    st_working   = 2'b10
  } map_state_t;

endpackage

/* logic/map_position_counter.sv */
`timescale 1ns/100ps

module map_position_counter (
  input  logic              clk,
  input  logic              nrst,
  input  logic              clr,
  input  logic              adv,
  output map_pkg::map_pos_t pos,
  output logic              last_col,
  output logic              last_pixel
);

  localparam map_pkg::col_t COL_LAST = map_pkg::col_t'(map_pkg::MAP_COLS - 1);
  localparam map_pkg::row_t ROW_LAST = map_pkg::row_t'(map_pkg::MAP_ROWS - 1);

  assign last_col = (pos.col == COL_LAST);
  assign last_pixel = last_col & (pos.row == ROW_LAST);

  // column is the PU number, row doubles as the round
  always_ff @(posedge clk or negedge nrst)
  begin
    if (!nrst)
    begin
      pos <= '0;
    end
    else if (clr)
    begin
      pos <= '0;
    end
    else if (adv)
    begin
      if (last_col)
      begin
        pos.col <= '0;
        // row saturates on the final row
        if (pos.row != ROW_LAST)
        begin
          pos.row <= pos.row + 1'b1;
        end
      end
      else
      begin
        pos.col <= pos.col + 1'b1;
      end
    end
  end

endmodule

/* run.sh */
#!/usr/bin/env bash
# build and run the column filter testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module map_filter_tb \
  --Mdir obj_dir -f list.f
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

sim_out=$(./obj_dir/Vmap_filter_tb 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "^TEST PASSED$"; then
  exit 0
fi
exit 1

/* tb/map_filter_assert.sv */
`timescale 1ns/100ps

module map_filter_assert (
  input logic              clk,
  input logic              nrst,
  input apb_pkg::apb_req_t req,
  input apb_pkg::apb_rsp_t rsp,
  input logic              pix_valid,
  input logic              busy,
  input logic              emit,
  input logic              res_valid
);

  int fail_cnt = 0;

  // pixels only reach the datapath once a map is started
  pix_not_idle: assert property (@(posedge clk) disable iff (!nrst) pix_valid |-> busy)
  else
  begin
    $error("pixel accepted while the control FSM is idle");
    fail_cnt++;
  end

  // a result only follows a pixel accepted in working
  res_after_emit: assert property (@(posedge clk) disable iff (!nrst)
    res_valid |-> $past(pix_valid && emit))
  else
  begin
    $error("result valid without a pixel write in the working state");
    fail_cnt++;
  end

  // reads and control or status writes never wait
  ready_first_access: assert property (@(posedge clk) disable iff (!nrst)
    (req.psel && req.penable && !(req.pwrite && req.paddr == apb_pkg::REG_PIXEL))
      |-> rsp.pready)
  else
  begin
    $error("pready withheld on a transfer that must finish in its first access cycle");
    fail_cnt++;
  end

endmodule

bind map_filter_top map_filter_assert i_map_filter_assert (
  .clk(clk), .nrst(nrst), .req(req), .rsp(rsp), .pix_valid(pix_valid),
  .busy(busy), .emit(emit), .res_valid(res_valid)
);

/* tb/map_filter_tb.sv */
`timescale 1ns/100ps

module map_filter_tb;

  localparam int unsigned SEED = 32'h7b0b_0fc1;
  localparam int PIXELS = map_pkg::MAP_ROWS * map_pkg::MAP_COLS;
  localparam int RESULTS = (map_pkg::MAP_ROWS - map_pkg::BUF_ROWS) * map_pkg::MAP_COLS;
  // reset checks, two images, busy start and the held write
  localparam int N_XFERS = 2 + 2 * (PIXELS + RESULTS + 4) + 2;
  localparam int TIMEOUT_CYCLES = 20 * N_XFERS;
  localparam int WAIT_LIMIT = 64;
  localparam int STALL_WAIT = 8;

  logic              clk;
  logic              nrst;
  apb_pkg::apb_req_t req;
  apb_pkg::apb_rsp_t rsp;

  logic [7:0]  img [map_pkg::MAP_ROWS][map_pkg::MAP_COLS];
  logic [31:0] exp_q [$];
  logic [31:0] got_q [$];
  logic [31:0] got_word;
  logic [31:0] exp_word;
  int          result_err_cnt = 0;
  int          status_err_cnt = 0;
  int          other_err_cnt = 0;
  int          cycles;

  map_filter_top i_map_filter_top (
    .clk(clk), .nrst(nrst), .req(req), .rsp(rsp)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // sum of the pixel and the four above it in the same column
  function automatic logic [10:0] ref_col_sum(input int row, input int col);
    logic [10:0] s;
    s = '0;
    for (int r = row - (map_pkg::WIN_ROWS - 1); r <= row; r++)
    begin
      s = s + 11'(img[r][col]);
    end
    return s;
  endfunction

  function automatic logic [31:0] result_word(input int row, input int col);
    return {3'b0, 5'(col), 3'b0, 5'(row), 5'b0, ref_col_sum(row, col)};
  endfunction

  // setup, access, then wait for pready or give the bus back
  task automatic bus_transfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                              input int max_wait, output logic ok, output logic [31:0] rdata,
                              output logic err);
    int waited;
    waited = 0;
    ok = 1'b0;
    rdata = '0;
    err = 1'b0;
    @(posedge clk);
    req.psel <= 1'b1;
    req.penable <= 1'b0;
    req.pwrite <= wr;
    req.paddr <= addr;
    req.pwdata <= wdata;
    @(posedge clk);
    req.penable <= 1'b1;
    while (!ok && waited < max_wait)
    begin
      @(negedge clk);
      ok = rsp.pready;
      rdata = rsp.prdata;
      err = rsp.pslverr;
      @(posedge clk);
      waited++;
    end
    req.psel <= 1'b0;
    req.penable <= 1'b0;
  endtask

  task automatic write_reg(input logic [3:0] addr, input logic [31:0] data, input int max_wait,
                           output logic ok);
    logic [31:0] rdata;
    logic        err;
    bus_transfer(1'b1, addr, data, max_wait, ok, rdata, err);
  endtask

  task automatic read_reg(input logic [3:0] addr, output logic [31:0] data, output logic err);
    logic ok;
    bus_transfer(1'b0, addr, 32'h0, WAIT_LIMIT, ok, data, err);
    assert (ok) else
    begin
      $display("register read was never accepted at %0t", $time);
      other_err_cnt++;
    end
  endtask

  task automatic send_start();
    logic ok;
    write_reg(apb_pkg::REG_CTRL, 32'h1, WAIT_LIMIT, ok);
    assert (ok) else
    begin
      $display("start write was never accepted at %0t", $time);
      other_err_cnt++;
    end
  endtask

  task automatic write_pixel(input logic [7:0] value);
    logic ok;
    write_reg(apb_pkg::REG_PIXEL, {24'h0, value}, WAIT_LIMIT, ok);
    assert (ok) else
    begin
      $display("pixel write was never accepted at %0t", $time);
      other_err_cnt++;
    end
  endtask

  task automatic check_status(input logic [2:0] expected, input string what);
    logic [31:0] data;
    logic        err;
    read_reg(apb_pkg::REG_STATUS, data, err);
    assert (data[2:0] == expected) else
    begin
      $display("Mismatch at %0t: status %s expected %b got %b", $time, what, expected, data[2:0]);
      status_err_cnt++;
    end
  endtask

  task automatic read_result(input int row, input int col);
    logic [31:0] data;
    logic        err;
    exp_q.push_back(result_word(row, col));
    read_reg(apb_pkg::REG_RESULT, data, err);
    assert (!err) else
    begin
      $display("result register was empty at row %0d col %0d, time %0t", row, col, $time);
      other_err_cnt++;
    end
    got_q.push_back(data);
  endtask

  task automatic run_image(input logic with_extras);
    logic ok;
    for (int r = 0; r < map_pkg::MAP_ROWS; r++)
    begin
      for (int c = 0; c < map_pkg::MAP_COLS; c++)
      begin
        img[r][c] = 8'($urandom);
      end
    end
    send_start();
    check_status(3'b001, "after start");
    for (int r = 0; r < map_pkg::MAP_ROWS; r++)
    begin
      for (int c = 0; c < map_pkg::MAP_COLS; c++)
      begin
        if (with_extras && r == 2 && c == 10)
        begin
          // ignored while busy
          send_start();
        end
        if (r == map_pkg::BUF_ROWS && c == 0)
        begin
          check_status(3'b001, "after buffering");
        end
        write_pixel(img[r][c]);
        if (r >= map_pkg::BUF_ROWS)
        begin
          if (with_extras && r == 10 && c == 5)
          begin
            // result still pending, so the next pixel must be held off
            write_reg(apb_pkg::REG_PIXEL, {24'h0, img[r][c+1]}, STALL_WAIT, ok);
            assert (!ok) else
            begin
              $display("pixel write was not held back while a result was pending");
              other_err_cnt++;
            end
          end
          read_result(r, c);
        end
      end
    end
    check_status(3'b010, "after last pixel");
  endtask

  initial
  begin
    forever
    begin
      @(posedge clk);
      while (got_q.size() > 0 && exp_q.size() > 0)
      begin
        got_word = got_q.pop_front();
        exp_word = exp_q.pop_front();
        assert (got_word == exp_word) else
        begin
          $display("Mismatch at %0t: result expected %h got %h", $time, exp_word, got_word);
          result_err_cnt++;
        end
      end
    end
  end

  initial
  begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: test did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  initial
  begin
    logic [31:0] data;
    logic        err;
    int          assert_err_cnt;
    nrst = 1'b0;
    req = '0;
    void'($urandom(SEED));
    repeat (5) @(posedge clk);
    nrst <= 1'b1;
    check_status(3'b000, "after reset");
    read_reg(apb_pkg::REG_RESULT, data, err);
    assert (err) else
    begin
      $display("read of the empty result register did not flag pslverr");
      other_err_cnt++;
    end
    run_image(1'b1);
    run_image(1'b0);
    repeat (4) @(posedge clk);
    assert (exp_q.size() == 0 && got_q.size() == 0) else
    begin
      $display("results left unchecked at the end of the run");
      other_err_cnt++;
    end
    assert_err_cnt = i_map_filter_top.i_map_filter_assert.fail_cnt;
    $display("errors: %0d result, %0d status, %0d other, %0d assertion",
             result_err_cnt, status_err_cnt, other_err_cnt, assert_err_cnt);
    if (result_err_cnt == 0 && status_err_cnt == 0 && other_err_cnt == 0 && assert_err_cnt == 0)
    begin
      $display("TEST PASSED");
    end
    else
    begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
